/* design/aluArray.sv */
`default_nettype none

module aluArray #(
    parameter int LANES = 4
) (
    input  wire logic              clk,
    input  wire logic              rstN,
    // command port
    input  wire logic              cmdValid,
    output logic                   cmdReady,
    input  wire aluPkg::opcode_t   cmdOp,
    input  wire aluPkg::word_t     cmdA,
    input  wire aluPkg::word_t     cmdB,
    // result port
    output logic                   resValid,
    input  wire logic              resReady,
    output aluPkg::word_t          resData
);

    import aluPkg::*;

    // dispatcher to lanes
    logic [LANES-1:0]  laneInValid;
    logic [LANES-1:0]  laneInReady;
    opcode_t           laneOp;
    word_t             laneA;
    word_t             laneB;

    // lanes to collector
    logic [LANES-1:0]  laneOutValid;
    logic [LANES-1:0]  laneOutReady;
    word_t [LANES-1:0] laneOutData;

    // round-robin command steering
    opDispatch #(
        .LANES (LANES)
    ) dispatch (
        .clk         (clk),
        .rstN        (rstN),
        .cmdValid    (cmdValid),
        .cmdReady    (cmdReady),
        .cmdOp       (cmdOp),
        .cmdA        (cmdA),
        .cmdB        (cmdB),
        .laneInValid (laneInValid),
        .laneInReady (laneInReady),
        .laneOp      (laneOp),
        .laneA       (laneA),
        .laneB       (laneB)
    );

    // identical lanes on the shared operand bus
    for (genvar i = 0; i < LANES; i++) begin : gLane
        aluLane lane (
            .clk      (clk),
            .rstN     (rstN),
            .inValid  (laneInValid[i]),
            .inReady  (laneInReady[i]),
            .op       (laneOp),
            .a        (laneA),
            .b        (laneB),
            .outValid (laneOutValid[i]),
            .outReady (laneOutReady[i]),
            .outData  (laneOutData[i])
        );
    end

    // in-order drain of lane results
    resultCollect #(
        .LANES (LANES)
    ) collect (
        .clk          (clk),
        .rstN         (rstN),
        .laneOutValid (laneOutValid),
        .laneOutData  (laneOutData),
        .laneOutReady (laneOutReady),
        .resValid     (resValid),
        .resReady     (resReady),
        .resData      (resData)
    );

endmodule

`default_nettype wire

/* design/aluLane.sv */
`default_nettype none

module aluLane (
    input  wire logic              clk,
    input  wire logic              rstN,
    // command in
    input  wire logic              inValid,
    output logic                   inReady,
    input  wire aluPkg::opcode_t   op,
    input  wire aluPkg::word_t     a,
    input  wire aluPkg::word_t     b,
    // result out
    output logic                   outValid,
    input  wire logic              outReady,
    output aluPkg::word_t          outData
);

    import aluPkg::*;

    // combinational result of the current command
    word_t aluResult;
    logic  inFire;

    // sixteen-function ALU on the shared operands
    always_comb begin
        case (op)
            OP_ADD: begin
                aluResult = a + b;
            end
            OP_SUB: begin
                aluResult = a - b;
            end
            OP_MUL: begin
                // upper product bits are dropped
                aluResult = a * b;
            end
            OP_DIV: begin
                // zero divisor saturates
                if (b == '0) begin
                    aluResult = '1;
                end else begin
                    aluResult = a / b;
                end
            end
            OP_SHL: begin
                aluResult = a << 1;
            end
            OP_SHR: begin
                aluResult = a >> 1;
            end
            OP_ROL: begin
                aluResult = {a[DATA_W-2:0], a[DATA_W-1]};
            end
            OP_ROR: begin
                aluResult = {a[0], a[DATA_W-1:1]};
            end
            OP_AND: begin
                aluResult = a & b;
            end
            OP_OR: begin
                aluResult = a | b;
            end
            OP_XOR: begin
                aluResult = a ^ b;
            end
            OP_NOR: begin
                aluResult = ~(a | b);
            end
            OP_NAND: begin
                aluResult = ~(a & b);
            end
            OP_XNOR: begin
                aluResult = ~(a ^ b);
            end
            OP_GT: begin
                aluResult = (a > b) ? word_t'(1) : word_t'(0);
            end
            OP_EQ: begin
                aluResult = (a == b) ? word_t'(1) : word_t'(0);
            end
            default: begin
                aluResult = '0;
            end
        endcase
    end

    // room when empty or when the held result leaves this cycle
    assign inReady = !outValid || outReady;
    assign inFire  = inValid && inReady;

    // valid flag of the one-entry buffer
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (inFire) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    // payload of the one-entry buffer
    always_ff @(posedge clk) begin
        if (inFire) begin
            outData <= aluResult;
        end
    end

endmodule

`default_nettype wire

/* design/aluPkg.sv */
`default_nettype none

package aluPkg;

    // operand and result width
    localparam int DATA_W = 16;

    // data word carried on operands and results
    typedef logic [DATA_W-1:0] word_t;

    // four-bit operation code, sixteen functions
    typedef logic [3:0] opcode_t;

    // arithmetic group
    localparam opcode_t OP_ADD = 4'd0;
    localparam opcode_t OP_SUB = 4'd1;
    // low half of the product only
    localparam opcode_t OP_MUL = 4'd2;
    // divide by zero gives all ones
    localparam opcode_t OP_DIV = 4'd3;

    // shift and rotate group, always by one bit
    localparam opcode_t OP_SHL = 4'd4;
    localparam opcode_t OP_SHR = 4'd5;
    localparam opcode_t OP_ROL = 4'd6;
    localparam opcode_t OP_ROR = 4'd7;

    // bitwise group
    localparam opcode_t OP_AND = 4'd8;
    localparam opcode_t OP_OR = 4'd9;
    localparam opcode_t OP_XOR = 4'd10;
    localparam opcode_t OP_NOR = 4'd11;

    // inverted bitwise group
    localparam opcode_t OP_NAND = 4'd12;
    localparam opcode_t OP_XNOR = 4'd13;

    // compare group, result is 1 or 0
    // unsigned compare
    localparam opcode_t OP_GT = 4'd14;
    localparam opcode_t OP_EQ = 4'd15;

endpackage

`default_nettype wire

/* design/opDispatch.sv */
`default_nettype none

module opDispatch #(
    parameter int LANES = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    // command side
    input  wire logic                   cmdValid,
    output logic                        cmdReady,
    input  wire aluPkg::opcode_t        cmdOp,
    input  wire aluPkg::word_t          cmdA,
    input  wire aluPkg::word_t          cmdB,
    // lane side
    output logic [LANES-1:0]            laneInValid,
    input  wire logic [LANES-1:0]       laneInReady,
    output aluPkg::opcode_t             laneOp,
    output aluPkg::word_t               laneA,
    output aluPkg::word_t               laneB
);

    // pointer needs at least one bit, even with a single lane
    localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

    typedef logic [PTR_W-1:0] laneIdx_t;

    // index of the highest lane, where the pointer wraps
    localparam laneIdx_t LAST_LANE = laneIdx_t'(LANES - 1);

    // lane that takes the next command
    laneIdx_t dispPtr;
    logic     cmdFire;

    // shared bus, only the pointed lane sees valid
    assign laneOp = cmdOp;
    assign laneA  = cmdA;
    assign laneB  = cmdB;

    // one-hot valid toward the pointed lane
    always_comb begin
        laneInValid          = '0;
        laneInValid[dispPtr] = cmdValid;
    end

    // back-pressure comes from the pointed lane alone
    assign cmdReady = laneInReady[dispPtr];
    assign cmdFire  = cmdValid && cmdReady;

    // round-robin step on each accepted command
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dispPtr <= '0;
        end else if (cmdFire) begin
            if (dispPtr == LAST_LANE) begin
                dispPtr <= '0;
            end else begin
                dispPtr <= dispPtr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/resultCollect.sv */
`default_nettype none

module resultCollect #(
    parameter int LANES = 4
) (
    input  wire logic                        clk,
    input  wire logic                        rstN,
    // lane side
    input  wire logic [LANES-1:0]            laneOutValid,
    input  wire aluPkg::word_t [LANES-1:0]   laneOutData,
    output logic [LANES-1:0]                 laneOutReady,
    // result side
    output logic                             resValid,
    input  wire logic                        resReady,
    output aluPkg::word_t                    resData
);

    import aluPkg::*;

    // same pointer width rule as the dispatcher
    localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

    typedef logic [PTR_W-1:0] laneIdx_t;

    localparam laneIdx_t LAST_LANE = laneIdx_t'(LANES - 1);

    // lane holding the oldest result
    laneIdx_t collPtr;
    word_t    selData;
    logic     resFire;

    // output mux under the pointer
    assign selData  = laneOutData[collPtr];
    assign resData  = selData;
    assign resValid = laneOutValid[collPtr];
    assign resFire  = resValid && resReady;

    // ready reaches the pointed lane only
    always_comb begin
        laneOutReady          = '0;
        laneOutReady[collPtr] = resReady;
    end

    // rotation matches the dispatcher, so command order holds
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            collPtr <= '0;
        end else if (resFire) begin
            if (collPtr == LAST_LANE) begin
                collPtr <= '0;
            end else begin
                collPtr <= collPtr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the ALU array testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module aluArrayTb -o simv
# a failing run is judged from the log below
./obj_dir/simv +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -q "PASS: all tests" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* sim.f */
design/aluPkg.sv
design/opDispatch.sv
design/aluLane.sv
design/resultCollect.sv
design/aluArray.sv
test/clockGen.sv
test/aluArray_assert.sv
test/aluArrayTb.sv

/* test/aluArrayTb.sv */
`default_nettype none

module aluArrayTb;

    timeunit 1ns;
    timeprecision 1ps;

    import aluPkg::*;

    localparam int LANES = 4;
    localparam int WAIT_LIMIT = 200;

    logic    clk;
    logic    rstN;
    logic    cmdValid;
    logic    cmdReady;
    opcode_t cmdOp;
    word_t   cmdA;
    word_t   cmdB;
    logic    resValid;
    logic    resReady;
    word_t   resData;

    // random state
    int          seed = 32'h0efb5a3c;
    logic [31:0] randWord;
    logic [31:0] randB;
    logic [31:0] readyWord;
    logic        randomReady;
    // transfer counts
    int          sentCount = 0;
    int          gotCount = 0;

    // wrap cases for add, sub, mul and the rotates
    word_t dirA [4] = '{16'h1234, 16'hFFFF, 16'h0001, 16'h8001};
    word_t dirB [4] = '{16'h00FF, 16'h0002, 16'h0002, 16'h8001};

    clockGen clocks (
        .clk  (clk),
        .rstN (rstN)
    );

    aluArray #(
        .LANES (LANES)
    ) aluArray_i (
        .clk      (clk),
        .rstN     (rstN),
        .cmdValid (cmdValid),
        .cmdReady (cmdReady),
        .cmdOp    (cmdOp),
        .cmdA     (cmdA),
        .cmdB     (cmdB),
        .resValid (resValid),
        .resReady (resReady),
        .resData  (resData)
    );

    always @(posedge clk) begin
        if (cmdValid && cmdReady) begin
            sentCount++;
        end
        if (resValid && resReady) begin
            gotCount++;
        end
    end

    // stop at the first assertion failure
    always @(negedge clk) begin
        if (aluArray_i.chk.errorCount != 0) begin
            $display("FAIL: see errors above");
            $fatal(1, "assertion failure");
        end
    end

    task automatic failTimeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on timeout");
    endtask

    // step to the next falling edge with optional random back-pressure
    task automatic nextCycle();
        @(negedge clk);
        if (randomReady) begin
            readyWord = $random(seed);
            resReady = readyWord[0];
        end
    endtask

    // starts on a falling edge and returns on the falling edge after the transfer
    task automatic sendCmd(input opcode_t op, input word_t a, input word_t b);
        int waited;
        waited = 0;
        cmdValid = 1'b1;
        cmdOp = op;
        cmdA = a;
        cmdB = b;
        #1;
        while (!cmdReady) begin
            nextCycle();
            #1;
            waited++;
            if (waited > WAIT_LIMIT) begin
                failTimeout("cmdReady");
            end
        end
        nextCycle();
    endtask

    task automatic drainResults();
        int waited;
        waited = 0;
        while (gotCount != sentCount) begin
            nextCycle();
            waited++;
            if (waited > WAIT_LIMIT) begin
                failTimeout("results to drain");
            end
        end
    endtask

    initial begin
        int waited;
        int i;
        int opIdx;
        cmdValid = 1'b0;
        cmdOp = '0;
        cmdA = '0;
        cmdB = '0;
        resReady = 1'b0;
        randomReady = 1'b0;
        // wait for reset release
        waited = 0;
        while (rstN !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                failTimeout("reset release");
            end
        end
        nextCycle();
        // all opcodes back to back at full throughput
        resReady = 1'b1;
        for (i = 0; i < 4; i++) begin
            for (opIdx = 0; opIdx < 16; opIdx++) begin
                sendCmd(opcode_t'(opIdx), dirA[i], dirB[i]);
            end
        end
        cmdValid = 1'b0;
        drainResults();
        // divide by zero
        sendCmd(OP_DIV, 16'h1234, 16'h0000);
        sendCmd(OP_DIV, 16'h0000, 16'h0000);
        cmdValid = 1'b0;
        drainResults();
        // lanes fill under a stalled output until cmdReady drops
        resReady = 1'b0;
        cmdValid = 1'b1;
        cmdOp = OP_MUL;
        cmdA = 16'h0301;
        cmdB = 16'h0107;
        for (i = 0; i < 2 * LANES; i++) begin
            nextCycle();
        end
        // the pending command goes in once the output opens
        resReady = 1'b1;
        sendCmd(OP_MUL, 16'h0301, 16'h0107);
        cmdValid = 1'b0;
        drainResults();
        // random stream with toggling resReady
        randomReady = 1'b1;
        for (i = 0; i < 200; i++) begin
            randWord = $random(seed);
            randB = $random(seed);
            sendCmd(opcode_t'(randWord[3:0]), randWord[31:16], randB[15:0]);
        end
        cmdValid = 1'b0;
        randomReady = 1'b0;
        resReady = 1'b1;
        drainResults();
        repeat (2) nextCycle();
        if (aluArray_i.chk.errorCount == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "errors reported");
        end
    end

endmodule

`default_nettype wire

/* test/aluArray_assert.sv */
`default_nettype none

module aluArrayAssert #(
    parameter int LANES = 4
) (
    input wire logic            clk,
    input wire logic            rstN,
    input wire logic            cmdValid,
    input wire logic            cmdReady,
    input wire aluPkg::opcode_t cmdOp,
    input wire aluPkg::word_t   cmdA,
    input wire aluPkg::word_t   cmdB,
    input wire logic            resValid,
    input wire logic            resReady,
    input wire aluPkg::word_t   resData
);

    timeunit 1ns;
    timeprecision 1ps;

    import aluPkg::*;

    localparam logic [7:0] LANE_COUNT = 8'(LANES);

    // failure count watched by the testbench
    int errorCount = 0;

    // circular buffer of expected results in command order
    word_t      expMem [256];
    logic [7:0] wrIdx;
    logic [7:0] rdIdx;
    logic [7:0] inFlight;
    // resData one edge back
    word_t      heldData;
    logic       rstSeen;

    // reference table written out bit by bit
    function automatic word_t refResult(input opcode_t op, input word_t a, input word_t b);
        logic [31:0] product;
        product = {16'h0000, a} * {16'h0000, b};
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_MUL:  return product[15:0];
            // zero divisor gives all ones
            OP_DIV:  return (b == 16'h0000) ? 16'hFFFF : a / b;
            OP_SHL:  return {a[14:0], 1'b0};
            OP_SHR:  return {1'b0, a[15:1]};
            OP_ROL:  return {a[14:0], a[15]};
            OP_ROR:  return {a[0], a[15:1]};
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_NOR:  return ~(a | b);
            OP_NAND: return ~(a & b);
            OP_XNOR: return ~(a ^ b);
            OP_GT:   return {15'h0000, a > b};
            OP_EQ:   return {15'h0000, a == b};
            default: return 16'h0000;
        endcase
    endfunction

    // push on command transfer and pop on result transfer
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrIdx <= '0;
            rdIdx <= '0;
            rstSeen <= 1'b0;
        end else begin
            rstSeen <= 1'b1;
            if (cmdValid && cmdReady) begin
                expMem[wrIdx] <= refResult(cmdOp, cmdA, cmdB);
                wrIdx <= wrIdx + 8'd1;
            end
            if (resValid && resReady) begin
                rdIdx <= rdIdx + 8'd1;
            end
        end
    end

    always @(posedge clk) begin
        heldData <= resData;
    end

    assign inFlight = wrIdx - rdIdx;

    // idle outputs in reset and on the first edge after it
    resetState: assert property (@(posedge clk)
        (!rstN || !rstSeen) |-> !resValid && cmdReady)
    else begin
        $error("Fail resetState expected valid 0 ready 1 actual valid %b ready %b",
            resValid, cmdReady);
        errorCount++;
    end

    // every result matches the oldest expected one
    resultOrder: assert property (@(posedge clk) disable iff (!rstN)
        resValid && resReady |-> resData == expMem[rdIdx])
    else begin
        $error("Fail resultOrder expected %h actual %h", expMem[rdIdx], resData);
        errorCount++;
    end

    // stalled result holds still
    holdStable: assert property (@(posedge clk) disable iff (!rstN)
        resValid && !resReady |=> resValid && resData == heldData)
    else begin
        $error("Fail holdStable expected %h actual %h", heldData, resData);
        errorCount++;
    end

    // no more than LANES commands parked under a stall
    laneLimit: assert property (@(posedge clk) disable iff (!rstN)
        !resReady && inFlight >= LANE_COUNT |-> !cmdReady)
    else begin
        $error("Fail laneLimit expected %0d in flight actual %0d", LANES, inFlight + 8'd1);
        errorCount++;
    end

    // an open output lets a command in on every cycle
    throughput: assert property (@(posedge clk) disable iff (!rstN)
        resReady |-> cmdReady)
    else begin
        $error("Fail throughput expected cmdReady 1 actual %b", cmdReady);
        errorCount++;
    end

    // command next in line shows up one cycle later
    latency: assert property (@(posedge clk) disable iff (!rstN)
        cmdValid && cmdReady && resReady && (inFlight == 8'd0 || (inFlight == 8'd1 && resValid))
        |=> resValid)
    else begin
        $error("Fail latency expected resValid 1 actual %b", resValid);
        errorCount++;
    end

endmodule

bind aluArray aluArrayAssert #(
    .LANES (LANES)
) chk (
    .clk      (clk),
    .rstN     (rstN),
    .cmdValid (cmdValid),
    .cmdReady (cmdReady),
    .cmdOp    (cmdOp),
    .cmdA     (cmdA),
    .cmdB     (cmdB),
    .resValid (resValid),
    .resReady (resReady),
    .resData  (resData)
);

`default_nettype wire

/* test/clockGen.sv */
`default_nettype none

module clockGen (
    output logic clk,
    output logic rstN
);

    timeunit 1ns;
    timeprecision 1ps;

    // 8 ns period, free running
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // reset low for 8 rising edges, released on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

`default_nettype wire
